/* source/msu_params.svh */
`ifndef MSU_PARAMS_SVH
`define MSU_PARAMS_SVH

// Data buffer address width, 16 KiB of bytes
`define MSU_BUF_AW 14

// Command queue entries, output slot included
`define MSU_CMDQ_DEPTH 4

// Revision reported in the low bits of the status byte
`define MSU_REVISION 3'd1

`endif

/* source/msu_pkg.sv */
package msu_pkg;

  // Console register indices
  typedef enum logic [2:0] {
    REG_STATUS_SEEK0 = 3'd0,
    REG_DATA_SEEK1   = 3'd1,
    REG_ID_SEEK2     = 3'd2,
    REG_ID_SEEK3     = 3'd3,
    REG_ID_TRACK0    = 3'd4,
    REG_ID_TRACK1    = 3'd5,
    REG_ID_VOLUME    = 3'd6,
    REG_ID_CTRL      = 3'd7
  } msu_reg_e;

  // Request kinds handed to the MCU
  typedef enum logic [1:0] {
    CMD_SEEK   = 2'd0,
    CMD_TRACK  = 2'd1,
    CMD_VOLUME = 2'd2,
    CMD_CTRL   = 2'd3
  } msu_cmd_e;

  // Status flag order in the MCU set and clear vectors
  //   bit 3  data_busy
  //   bit 2  audio_busy
  //   bit 1  audio_playing
  //   bit 0  audio_repeat

endpackage

/* source/msu_bus_sync.sv */
`timescale 1ns/1ps

module msu_bus_sync (
  input  logic               clkin,
  input  logic               rst,
  input  logic [2:0]         reg_addr,
  input  logic [7:0]         reg_data_in,
  input  logic               reg_we,
  input  logic               reg_oe,
  input  logic               ptr_load,
  input  logic               status_we,
  output logic               wr_ev,
  output logic               rd_end_ev,
  output logic               ptr_ev,
  output logic               stat_ev,
  output msu_pkg::msu_reg_e  ev_addr,
  output logic [7:0]         ev_data
);

  import msu_pkg::*;

  // Strobe positions in the sync vector
  localparam int S_WE   = 0;
  localparam int S_OE   = 1;
  localparam int S_PTR  = 2;
  localparam int S_STAT = 3;

  logic [3:0] strobe_in;
  logic [3:0] sync1;
  logic [3:0] sync2;
  logic [3:0] hist;
  logic [3:0] rise;
  logic [3:0] fall;

  assign strobe_in = {status_we, ptr_load, reg_oe, reg_we};

  ////////////////////
  // Two-flop synchronizer plus history
  always_ff @(posedge clkin) begin
    if (rst) begin
      sync1 <= '0;
      sync2 <= '0;
      hist  <= '0;
    end else begin
      sync1 <= strobe_in;
      sync2 <= sync1;
      hist  <= sync2;
    end
  end

  assign rise = sync2 & ~hist;
  assign fall = ~sync2 & hist;

  // Registered events, three cycles after the input edge
  always_ff @(posedge clkin) begin
    if (rst) begin
      wr_ev     <= 1'b0;
      rd_end_ev <= 1'b0;
      ptr_ev    <= 1'b0;
      stat_ev   <= 1'b0;
    end else begin
      wr_ev     <= rise[S_WE];
      rd_end_ev <= fall[S_OE];
      ptr_ev    <= rise[S_PTR];
      stat_ev   <= rise[S_STAT];
    end
  end

  // Bus is stable while the strobe is held, so sample it at the edge.
  // A read start also records its address for the read end event
  always_ff @(posedge clkin) begin
    if (rise[S_WE]) begin
      ev_addr <= msu_reg_e'(reg_addr);
      ev_data <= reg_data_in;
    end else if (rise[S_OE]) begin
      ev_addr <= msu_reg_e'(reg_addr);
    end
  end

endmodule

/* source/msu_databuf.sv */
`timescale 1ns/1ps

`include "msu_params.svh"

module msu_databuf (
  input  logic                   clkin,
  input  logic                   wr_en,
  input  logic [`MSU_BUF_AW-1:0] wr_addr,
  input  logic [7:0]             wr_data,
  input  logic [`MSU_BUF_AW-1:0] rd_addr,
  output logic [7:0]             rd_data
);

  localparam int BUF_BYTES = 2 ** `MSU_BUF_AW;

  logic [7:0] mem [BUF_BYTES];

  ////////////////////
  // MCU write port
  always_ff @(posedge clkin) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  ////////////////////
  // Console side read, one cycle latency
  // Re-reads every cycle so the output tracks MCU loads at the pointer
  always_ff @(posedge clkin) begin
    rd_data <= mem[rd_addr];
  end

endmodule

/* source/msu_regs.sv */
`timescale 1ns/1ps

`include "msu_params.svh"

module msu_regs (
  input  logic                   clkin,
  input  logic                   rst,
  input  logic                   wr_ev,
  input  logic                   rd_end_ev,
  input  logic                   ptr_ev,
  input  logic                   stat_ev,
  input  msu_pkg::msu_reg_e      ev_addr,
  input  logic [7:0]             ev_data,
  input  msu_pkg::msu_reg_e      reg_addr,
  input  logic [`MSU_BUF_AW-1:0] ptr_value,
  input  logic [3:0]             status_set,
  input  logic [3:0]             status_clear,
  input  logic [7:0]             buf_data,
  input  logic                   q_full,
  input  logic                   q_overflow,
  output logic [7:0]             reg_data_out,
  output logic [`MSU_BUF_AW-1:0] buf_addr,
  output logic                   push,
  output msu_pkg::msu_cmd_e      push_kind,
  output logic [31:0]            push_arg
);

  import msu_pkg::*;

  // Flag bit positions, same order as the MCU vectors
  localparam int FLAG_DATA_BUSY  = 3;
  localparam int FLAG_AUDIO_BUSY = 2;

  // Identification text for registers 2 to 7
  localparam logic [47:0] ID_STRING = "S-MSU1";

  logic [3:0]             status_flags;
  logic [3:0]             status_flags_n;
  logic                   ovf_sticky;
  logic [`MSU_BUF_AW-1:0] rd_ptr;
  logic [23:0]            seek_lo;
  logic [7:0]             track_lo;
  logic [7:0]             status_byte;

  logic                   cmd_hit;
  msu_cmd_e               cmd_kind_d;
  logic [31:0]            cmd_arg_d;

  ////////////////////
  // Command decode
  always_comb begin
    cmd_hit    = 1'b0;
    cmd_kind_d = CMD_VOLUME;
    cmd_arg_d  = '0;
    if (wr_ev) begin
      case (ev_addr)
        REG_ID_SEEK3: begin
          cmd_hit    = 1'b1;
          cmd_kind_d = CMD_SEEK;
          cmd_arg_d  = {ev_data, seek_lo};
        end
        REG_ID_TRACK1: begin
          cmd_hit    = 1'b1;
          cmd_kind_d = CMD_TRACK;
          cmd_arg_d  = {16'h0000, ev_data, track_lo};
        end
        REG_ID_VOLUME: begin
          cmd_hit    = 1'b1;
          cmd_kind_d = CMD_VOLUME;
          cmd_arg_d  = {24'h000000, ev_data};
        end
        REG_ID_CTRL: begin
          // Playback control is locked out while a track is loading
          if (!status_flags[FLAG_AUDIO_BUSY]) begin
            cmd_hit    = 1'b1;
            cmd_kind_d = CMD_CTRL;
            cmd_arg_d  = {30'h0, ev_data[1:0]};
          end
        end
        default: begin
        end
      endcase
    end
  end

  always_ff @(posedge clkin) begin
    if (rst) begin
      push <= 1'b0;
    end else begin
      push <= cmd_hit;
    end
  end

  // Partial offset and track bytes, plus the pushed payload
  always_ff @(posedge clkin) begin
    if (wr_ev) begin
      case (ev_addr)
        REG_STATUS_SEEK0: seek_lo[7:0]   <= ev_data;
        REG_DATA_SEEK1:   seek_lo[15:8]  <= ev_data;
        REG_ID_SEEK2:     seek_lo[23:16] <= ev_data;
        REG_ID_TRACK0:    track_lo       <= ev_data;
        default: begin
        end
      endcase
    end
    if (cmd_hit) begin
      push_kind <= cmd_kind_d;
      push_arg  <= cmd_arg_d;
    end
  end

  ////////////////////
  // Status flags
  always_comb begin
    status_flags_n = status_flags;
    if (wr_ev && ev_addr == REG_ID_SEEK3) begin
      status_flags_n[FLAG_DATA_BUSY] = 1'b1;
    end
    if (wr_ev && ev_addr == REG_ID_TRACK1) begin
      status_flags_n[FLAG_AUDIO_BUSY] = 1'b1;
    end
    // Set first, then clear wins
    if (stat_ev) begin
      status_flags_n = (status_flags_n | status_set) & ~status_clear;
    end
  end

  always_ff @(posedge clkin) begin
    if (rst) begin
      status_flags <= 4'b1100;
    end else begin
      status_flags <= status_flags_n;
    end
  end

  // Lost command, seen at push time or reported by the queue
  always_ff @(posedge clkin) begin
    if (rst) begin
      ovf_sticky <= 1'b0;
    end else if (q_overflow || (push && q_full)) begin
      ovf_sticky <= 1'b1;
    end else if (ptr_ev) begin
      ovf_sticky <= 1'b0;
    end
  end

  ////////////////////
  // Read pointer
  // MCU load has priority over the console's auto increment
  always_ff @(posedge clkin) begin
    if (rst) begin
      rd_ptr <= '0;
    end else if (ptr_ev) begin
      rd_ptr <= ptr_value;
    end else if (rd_end_ev && ev_addr == REG_DATA_SEEK1) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

  assign buf_addr = rd_ptr;

  ////////////////////
  // Read mux
  assign status_byte = {status_flags, ovf_sticky, `MSU_REVISION};

  always_ff @(posedge clkin) begin
    case (reg_addr)
      REG_STATUS_SEEK0: reg_data_out <= status_byte;
      REG_DATA_SEEK1:   reg_data_out <= buf_data;
      REG_ID_SEEK2:     reg_data_out <= ID_STRING[47:40];
      REG_ID_SEEK3:     reg_data_out <= ID_STRING[39:32];
      REG_ID_TRACK0:    reg_data_out <= ID_STRING[31:24];
      REG_ID_TRACK1:    reg_data_out <= ID_STRING[23:16];
      REG_ID_VOLUME:    reg_data_out <= ID_STRING[15:8];
      REG_ID_CTRL:      reg_data_out <= ID_STRING[7:0];
      default:          reg_data_out <= 8'h00;
    endcase
  end

endmodule

/* source/msu_cmd_queue.sv */
`timescale 1ns/1ps

`include "msu_params.svh"

module msu_cmd_queue (
  input  logic              clkin,
  input  logic              rst,
  input  logic              push,
  input  msu_pkg::msu_cmd_e push_kind,
  input  logic [31:0]       push_arg,
  input  logic              cmd_ready,
  output logic              full,
  output logic              overflow,
  output logic              cmd_valid,
  output msu_pkg::msu_cmd_e cmd_kind,
  output logic [31:0]       cmd_arg
);

  import msu_pkg::*;

  localparam int DEPTH = `MSU_CMDQ_DEPTH;
  // Ring behind the output slot
  localparam int RING  = DEPTH - 1;
  localparam int PW    = (RING > 1) ? $clog2(RING) : 1;
  localparam int CW    = $clog2(DEPTH + 1);

  msu_cmd_e    kind_mem [RING];
  logic [31:0] arg_mem  [RING];

  logic [PW-1:0] rd_ptr;
  logic [PW-1:0] wr_ptr;
  logic [CW-1:0] ring_cnt;
  logic [CW-1:0] q_count;

  logic accept;
  logic slot_free;
  logic ring_empty;
  logic from_ring;
  logic to_ring;
  logic to_slot;

  function automatic logic [PW-1:0] ring_next(input logic [PW-1:0] p);
    return (p == PW'(RING - 1)) ? '0 : p + 1'b1;
  endfunction

  assign q_count    = ring_cnt + CW'(cmd_valid);
  assign full       = (q_count == CW'(DEPTH));
  assign accept     = push && !full;
  assign slot_free  = !cmd_valid || cmd_ready;
  assign ring_empty = (ring_cnt == '0);

  // Oldest ring entry refills the slot; a push skips the ring when it is empty
  assign from_ring = slot_free && !ring_empty;
  assign to_slot   = accept && slot_free && ring_empty;
  assign to_ring   = accept && !to_slot;

  ////////////////////
  // Control
  always_ff @(posedge clkin) begin
    if (rst) begin
      rd_ptr    <= '0;
      wr_ptr    <= '0;
      ring_cnt  <= '0;
      cmd_valid <= 1'b0;
      overflow  <= 1'b0;
    end else begin
      overflow <= push && full;
      if (to_ring) begin
        wr_ptr <= ring_next(wr_ptr);
      end
      if (from_ring) begin
        rd_ptr <= ring_next(rd_ptr);
      end
      ring_cnt <= ring_cnt + CW'(to_ring) - CW'(from_ring);
      if (slot_free) begin
        cmd_valid <= from_ring || to_slot;
      end
    end
  end

  ////////////////////
  // Payload, slot holds still while stalled
  always_ff @(posedge clkin) begin
    if (to_ring) begin
      kind_mem[wr_ptr] <= push_kind;
      arg_mem[wr_ptr]  <= push_arg;
    end
    if (from_ring) begin
      cmd_kind <= kind_mem[rd_ptr];
      cmd_arg  <= arg_mem[rd_ptr];
    end else if (to_slot) begin
      cmd_kind <= push_kind;
      cmd_arg  <= push_arg;
    end
  end

endmodule

/* source/msu_top.sv */
`timescale 1ns/1ps

`include "msu_params.svh"

module msu_top (
  input  logic                   clkin,
  input  logic                   rst,
  // Console bus
  input  logic [2:0]             reg_addr,
  input  logic [7:0]             reg_data_in,
  input  logic                   reg_we,
  input  logic                   reg_oe,
  output logic [7:0]             reg_data_out,
  // MCU side
  input  logic                   pgm_valid,
  input  logic [`MSU_BUF_AW-1:0] pgm_addr,
  input  logic [7:0]             pgm_data,
  input  logic                   ptr_load,
  input  logic [`MSU_BUF_AW-1:0] ptr_value,
  input  logic                   status_we,
  input  logic [3:0]             status_set,
  input  logic [3:0]             status_clear,
  // Command stream
  output logic                   cmd_valid,
  input  logic                   cmd_ready,
  output msu_pkg::msu_cmd_e      cmd_kind,
  output logic [31:0]            cmd_arg
);

  import msu_pkg::*;

  logic                   wr_ev;
  logic                   rd_end_ev;
  logic                   ptr_ev;
  logic                   stat_ev;
  msu_reg_e               ev_addr;
  logic [7:0]             ev_data;
  logic [`MSU_BUF_AW-1:0] buf_addr;
  logic [7:0]             buf_data;
  logic                   push;
  msu_cmd_e               push_kind;
  logic [31:0]            push_arg;
  logic                   q_full;
  logic                   q_overflow;

  msu_bus_sync u_sync (
    .clkin       (clkin),
    .rst         (rst),
    .reg_addr    (reg_addr),
    .reg_data_in (reg_data_in),
    .reg_we      (reg_we),
    .reg_oe      (reg_oe),
    .ptr_load    (ptr_load),
    .status_we   (status_we),
    .wr_ev       (wr_ev),
    .rd_end_ev   (rd_end_ev),
    .ptr_ev      (ptr_ev),
    .stat_ev     (stat_ev),
    .ev_addr     (ev_addr),
    .ev_data     (ev_data)
  );

  msu_regs u_regs (
    .clkin        (clkin),
    .rst          (rst),
    .wr_ev        (wr_ev),
    .rd_end_ev    (rd_end_ev),
    .ptr_ev       (ptr_ev),
    .stat_ev      (stat_ev),
    .ev_addr      (ev_addr),
    .ev_data      (ev_data),
    .reg_addr     (msu_reg_e'(reg_addr)),
    .ptr_value    (ptr_value),
    .status_set   (status_set),
    .status_clear (status_clear),
    .buf_data     (buf_data),
    .q_full       (q_full),
    .q_overflow   (q_overflow),
    .reg_data_out (reg_data_out),
    .buf_addr     (buf_addr),
    .push         (push),
    .push_kind    (push_kind),
    .push_arg     (push_arg)
  );

  msu_databuf u_databuf (
    .clkin   (clkin),
    .wr_en   (pgm_valid),
    .wr_addr (pgm_addr),
    .wr_data (pgm_data),
    .rd_addr (buf_addr),
    .rd_data (buf_data)
  );

  msu_cmd_queue u_cmdq (
    .clkin     (clkin),
    .rst       (rst),
    .push      (push),
    .push_kind (push_kind),
    .push_arg  (push_arg),
    .cmd_ready (cmd_ready),
    .full      (q_full),
    .overflow  (q_overflow),
    .cmd_valid (cmd_valid),
    .cmd_kind  (cmd_kind),
    .cmd_arg   (cmd_arg)
  );

endmodule

/* test/msu_tb.sv */
`timescale 1ns/1ps

`include "msu_params.svh"

module msu_tb;

  import msu_pkg::*;

  localparam int BUF_BYTES = 2 ** `MSU_BUF_AW;
  localparam int WAIT_LIMIT = 400;

  logic                   clkin = 1'b0;
  logic                   rst;
  logic [2:0]             reg_addr;
  logic [7:0]             reg_data_in;
  logic                   reg_we;
  logic                   reg_oe;
  logic [7:0]             reg_data_out;
  logic                   pgm_valid;
  logic [`MSU_BUF_AW-1:0] pgm_addr;
  logic [7:0]             pgm_data;
  logic                   ptr_load;
  logic [`MSU_BUF_AW-1:0] ptr_value;
  logic                   status_we;
  logic [3:0]             status_set;
  logic [3:0]             status_clear;
  logic                   cmd_valid;
  logic                   cmd_ready;
  msu_cmd_e               cmd_kind;
  logic [31:0]            cmd_arg;

  // Model of the register block, flags as {data_busy, audio_busy, playing, repeat}
  logic [3:0]             m_flags;
  logic                   m_ovf;
  logic [23:0]            m_seek_lo;
  logic [7:0]             m_track_lo;
  logic [`MSU_BUF_AW-1:0] m_ptr;
  logic [7:0]             buf_model [BUF_BYTES];

  // Scoreboard of commands still owed by the DUT
  msu_cmd_e    exp_kind [$];
  logic [31:0] exp_arg  [$];

  int errors = 0;
  int checks = 0;
  int ready_mode = 1;
  string id_text = "S-MSU1";

  msu_top dut0 (
    .clkin        (clkin),
    .rst          (rst),
    .reg_addr     (reg_addr),
    .reg_data_in  (reg_data_in),
    .reg_we       (reg_we),
    .reg_oe       (reg_oe),
    .reg_data_out (reg_data_out),
    .pgm_valid    (pgm_valid),
    .pgm_addr     (pgm_addr),
    .pgm_data     (pgm_data),
    .ptr_load     (ptr_load),
    .ptr_value    (ptr_value),
    .status_we    (status_we),
    .status_set   (status_set),
    .status_clear (status_clear),
    .cmd_valid    (cmd_valid),
    .cmd_ready    (cmd_ready),
    .cmd_kind     (cmd_kind),
    .cmd_arg      (cmd_arg)
  );

  always #10 clkin = ~clkin;

  ////////////////////
  // Reference model
  function automatic logic msu_expect_cmd(input msu_reg_e addr, input logic [7:0] data,
                                          input logic audio_busy, input logic [23:0] seek_lo,
                                          input logic [7:0] track_lo, output msu_cmd_e kind,
                                          output logic [31:0] arg);
    kind = CMD_VOLUME;
    arg  = '0;
    case (addr)
      REG_ID_SEEK3: begin
        kind = CMD_SEEK;
        arg  = {data, seek_lo};
        return 1'b1;
      end
      REG_ID_TRACK1: begin
        kind = CMD_TRACK;
        arg  = {16'h0000, data, track_lo};
        return 1'b1;
      end
      REG_ID_VOLUME: begin
        arg = {24'h000000, data};
        return 1'b1;
      end
      REG_ID_CTRL: begin
        // Locked out while a track loads
        kind = CMD_CTRL;
        arg  = {30'h0, data[1:0]};
        return !audio_busy;
      end
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [7:0] status_expect();
    return {m_flags, m_ovf, `MSU_REVISION};
  endfunction

  ////////////////////
  // Helpers
  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("Fail at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("*** FAILED ***");
    $finish;
  endtask

  task automatic report_test(input int num, input string name, input int err_before);
    $display("Test %0d %-24s %0d errors", num, name, errors - err_before);
  endtask

  task automatic bus_write(input msu_reg_e addr, input logic [7:0] data);
    msu_cmd_e    kind;
    logic [31:0] arg;
    logic        hit;
    hit = msu_expect_cmd(addr, data, m_flags[2], m_seek_lo, m_track_lo, kind, arg);
    if (hit && exp_kind.size() >= `MSU_CMDQ_DEPTH) begin
      m_ovf = 1'b1;
    end else if (hit) begin
      exp_kind.push_back(kind);
      exp_arg.push_back(arg);
    end
    case (addr)
      REG_STATUS_SEEK0: m_seek_lo[7:0]   = data;
      REG_DATA_SEEK1:   m_seek_lo[15:8]  = data;
      REG_ID_SEEK2:     m_seek_lo[23:16] = data;
      REG_ID_SEEK3:     m_flags[3]       = 1'b1;
      REG_ID_TRACK0:    m_track_lo       = data;
      REG_ID_TRACK1:    m_flags[2]       = 1'b1;
      default: begin
      end
    endcase
    @(posedge clkin);
    reg_addr    <= addr;
    reg_data_in <= data;
    reg_we      <= 1'b1;
    repeat (6) @(posedge clkin);
    reg_we <= 1'b0;
    repeat (6) @(posedge clkin);
  endtask

  task automatic bus_read(input msu_reg_e addr, output logic [7:0] data);
    @(posedge clkin);
    reg_addr <= addr;
    reg_oe   <= 1'b1;
    repeat (4) @(posedge clkin);
    @(negedge clkin);
    data = reg_data_out;
    @(posedge clkin);
    reg_oe <= 1'b0;
    // Let the read end event and the prefetch settle
    repeat (6) @(posedge clkin);
  endtask

  task automatic status_update(input logic [3:0] set_bits, input logic [3:0] clear_bits);
    m_flags = (m_flags | set_bits) & ~clear_bits;
    @(posedge clkin);
    status_set   <= set_bits;
    status_clear <= clear_bits;
    status_we    <= 1'b1;
    repeat (6) @(posedge clkin);
    status_we <= 1'b0;
    repeat (6) @(posedge clkin);
  endtask

  task automatic pointer_load(input logic [`MSU_BUF_AW-1:0] value);
    m_ptr = value;
    m_ovf = 1'b0;
    @(posedge clkin);
    ptr_value <= value;
    ptr_load  <= 1'b1;
    repeat (6) @(posedge clkin);
    ptr_load <= 1'b0;
    repeat (6) @(posedge clkin);
  endtask

  task automatic check_status();
    logic [7:0] got;
    bus_read(REG_STATUS_SEEK0, got);
    check_value("status", got, status_expect());
  endtask

  task automatic wait_drain(input string what);
    int cycles;
    cycles = 0;
    while ((exp_kind.size() != 0 || cmd_valid) && cycles < WAIT_LIMIT) begin
      @(posedge clkin);
      cycles++;
    end
    if (exp_kind.size() != 0 || cmd_valid) begin
      abort_run({"Timeout: command stream did not drain after ", what});
    end
  endtask

  task automatic wait_space();
    int cycles;
    cycles = 0;
    while (exp_kind.size() >= `MSU_CMDQ_DEPTH && cycles < WAIT_LIMIT) begin
      @(posedge clkin);
      cycles++;
    end
    if (exp_kind.size() >= `MSU_CMDQ_DEPTH) begin
      abort_run("Timeout: command queue never freed an entry");
    end
  endtask

  ////////////////////
  // Ready pattern for the command stream
  always @(posedge clkin) begin
    case (ready_mode)
      0:       cmd_ready <= 1'b0;
      1:       cmd_ready <= 1'b1;
      default: cmd_ready <= 1'($urandom_range(0, 1));
    endcase
  end

  // Compare every transfer with the scoreboard
  always @(negedge clkin) begin : cmd_checker
    logic        stalled;
    msu_cmd_e    held_kind;
    logic [31:0] held_arg;
    if (!rst) begin
      if (stalled) begin
        check_value("cmd_valid held", cmd_valid, 1'b1);
        check_value("cmd_kind held", cmd_kind, held_kind);
        check_value("cmd_arg held", cmd_arg, held_arg);
      end
      if (cmd_valid && cmd_ready) begin
        checks++;
        assert (exp_kind.size() > 0) else begin
          $display("Command of kind %s arrived when none was expected", cmd_kind.name());
          errors++;
        end
        if (exp_kind.size() > 0) begin
          check_value("cmd_kind", cmd_kind, exp_kind.pop_front());
          check_value("cmd_arg", cmd_arg, exp_arg.pop_front());
        end
      end
    end
    stalled   = !rst && cmd_valid && !cmd_ready;
    held_kind = cmd_kind;
    held_arg  = cmd_arg;
  end

  ////////////////////
  // Test sequence
  initial begin : main
    int         err_before;
    logic [7:0] got;
    logic [7:0] data;

    void'($urandom(32'h678c3ebf));
    rst          = 1'b1;
    reg_addr     = '0;
    reg_data_in  = '0;
    reg_we       = 1'b0;
    reg_oe       = 1'b0;
    pgm_valid    = 1'b0;
    pgm_addr     = '0;
    pgm_data     = '0;
    ptr_load     = 1'b0;
    ptr_value    = '0;
    status_we    = 1'b0;
    status_set   = '0;
    status_clear = '0;
    cmd_ready    = 1'b1;
    m_flags      = 4'b1100;
    m_ovf        = 1'b0;
    m_seek_lo    = '0;
    m_track_lo   = '0;
    m_ptr        = '0;
    repeat (4) @(posedge clkin);
    rst <= 1'b0;
    repeat (2) @(posedge clkin);

    // Reset values and identification
    err_before = errors;
    check_status();
    for (int r = 2; r < 8; r++) begin
      bus_read(msu_reg_e'(r), got);
      check_value($sformatf("id byte %0d", r), got, id_text[r - 2]);
    end
    report_test(1, "reset and identity", err_before);

    // Seek, track and volume requests, busy flags start clear
    err_before = errors;
    status_update(4'b0000, 4'b1100);
    check_status();
    for (int r = 0; r < 7; r++) begin
      bus_write(msu_reg_e'(r), 8'($urandom));
    end
    wait_drain("seek, track and volume writes");
    check_status();
    report_test(2, "seek track volume", err_before);

    // Data port against the buffer copy
    err_before = errors;
    for (int a = 0; a < BUF_BYTES; a++) begin
      data         = 8'($urandom);
      buf_model[a] = data;
      @(posedge clkin);
      pgm_valid <= 1'b1;
      pgm_addr  <= a[`MSU_BUF_AW-1:0];
      pgm_data  <= data;
    end
    @(posedge clkin);
    pgm_valid <= 1'b0;
    pointer_load(`MSU_BUF_AW'($urandom));
    for (int i = 0; i < 16; i++) begin
      bus_read(REG_DATA_SEEK1, got);
      check_value($sformatf("data byte at 0x%0h", m_ptr), got, buf_model[m_ptr]);
      m_ptr = m_ptr + 1'b1;
    end
    report_test(3, "data port", err_before);

    // Control gating on audio_busy
    err_before = errors;
    bus_write(REG_ID_CTRL, 8'($urandom));
    wait_drain("gated control write");
    status_update(4'b0000, 4'b0100);
    check_status();
    bus_write(REG_ID_CTRL, 8'($urandom));
    wait_drain("control write");
    status_update(4'b1011, 4'b1001);
    check_status();
    report_test(4, "control gating", err_before);

    // Back-pressure, overflow and a random ready pattern
    err_before = errors;
    ready_mode <= 0;
    for (int i = 0; i < 6; i++) begin
      bus_write(REG_ID_VOLUME, 8'($urandom));
    end
    check_status();
    ready_mode <= 1;
    wait_drain("stalled volume writes");
    check_status();
    ready_mode <= 2;
    for (int i = 0; i < 12; i++) begin
      wait_space();
      bus_write(msu_reg_e'($urandom_range(0, 6)), 8'($urandom));
    end
    ready_mode <= 1;
    wait_drain("random ready traffic");
    pointer_load('0);
    check_status();
    report_test(5, "back-pressure", err_before);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* filelist.f */
+incdir+source
source/msu_pkg.sv
source/msu_bus_sync.sv
source/msu_databuf.sv
source/msu_regs.sv
source/msu_cmd_queue.sv
source/msu_top.sv
test/msu_tb.sv

/* Bender.yml */
package:
  name: msu_regs

sources:
  - target: any(rtl, test)
    include_dirs:
      - source
    files:
      - source/msu_pkg.sv
      - source/msu_bus_sync.sv
      - source/msu_databuf.sv
      - source/msu_regs.sv
      - source/msu_cmd_queue.sv
      - source/msu_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - test/msu_tb.sv
